// File: compile.f
+incdir+.
instr_pkg.sv
rob_pkg.sv
exu_if.sv
ialu.sv
ibr.sv
idiv.sv
exe.sv
exe_top.sv
tb_exe.sv

// File: exe.sv
`include "exe_cfg.svh"

module exe (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  iss_valid,
    input  instr_pkg::t_uinstr    iss_uinstr,
    input  logic [`EXE_XLEN-1:0]  iss_src1,
    input  logic [`EXE_XLEN-1:0]  iss_src2,
    input  logic [`EXE_PRF_W-1:0] iss_pdst,
    input  logic [`EXE_ROB_W-1:0] iss_robid,
    input  logic                  br_mispred_rb1,
    output logic                  iss_ready,
    output logic                  prf_wr_en,
    output rob_pkg::t_prf_wr_pkt  prf_wr_pkt,
    output logic                  ro_valid,
    output rob_pkg::t_rob_result  ro_result
);
    import instr_pkg::*;
    import rob_pkg::*;

    logic                  issue;
    logic                  is_div;
    logic [`EXE_XLEN-1:0]  src2_sel;
    logic                  alu_vld;
    logic [`EXE_XLEN-1:0]  alu_res;
    logic                  br_vld;
    logic [`EXE_XLEN-1:0]  br_tgt;
    logic                  br_mispred;
    logic                  div_busy;
    logic                  div_done;
    logic [`EXE_XLEN-1:0]  div_res;
    logic [`EXE_PRF_W-1:0] div_pdst;
    logic [`EXE_ROB_W-1:0] div_robid;
    logic                  div_dst_reg;
    logic                  valid_ex0;
    logic                  wr_en_ex0;
    t_prf_wr_pkt           pkt_ex0;
    t_rob_result           rob_ex0;
    logic                  valid_ex1;
    logic                  wr_en_ex1;
    t_prf_wr_pkt           pkt_ex1;
    t_rob_result           rob_ex1;

    exu_if u_exu ();

    // Nothing is accepted while the divider owns the stage
    assign iss_ready = !div_busy;
    assign issue     = iss_valid & iss_uinstr.valid & iss_ready;
    assign is_div    = iss_uinstr.uop inside {U_DIVU, U_REMU};

    always_comb begin
        case (iss_uinstr.src2_kind)
            OP_REG:  src2_sel = iss_src2;
            OP_IMM:  src2_sel = iss_uinstr.imm;
            default: src2_sel = '0;
        endcase
    end

    assign u_exu.issue   = issue;
    assign u_exu.uinstr  = iss_uinstr;
    assign u_exu.src1val = iss_src1;
    assign u_exu.src2val = src2_sel;

    ialu u_ialu (
        .u      (u_exu),
        .resvld (alu_vld),
        .result (alu_res)
    );

    ibr u_ibr (
        .u          (u_exu),
        .resvld     (br_vld),
        .br_tgt     (br_tgt),
        .br_mispred (br_mispred)
    );

    idiv u_idiv (
        .clk    (clk),
        .rst_n  (rst_n),
        .u      (u_exu),
        .flush  (br_mispred_rb1),
        .busy   (div_busy),
        .done   (div_done),
        .result (div_res)
    );

    // Invalid and ecall complete with no data
    assign valid_ex0 = (issue & !is_div) | div_done;
    assign wr_en_ex0 = div_done ? div_dst_reg : alu_vld & iss_uinstr.dst_reg;

    always_comb begin
        pkt_ex0.data = '0;
        pkt_ex0.data |= alu_vld  ? alu_res : '0;
        pkt_ex0.data |= br_vld   ? br_tgt  : '0;
        pkt_ex0.data |= div_done ? div_res : '0;
        pkt_ex0.pdst = div_done ? div_pdst : iss_pdst;
        rob_ex0.robid = div_done ? div_robid : iss_robid;
        rob_ex0.mispred = br_vld & br_mispred;
    end

    always_ff @(posedge clk) begin
        if (issue && is_div) begin
            div_pdst    <= iss_pdst;
            div_robid   <= iss_robid;
            div_dst_reg <= iss_uinstr.dst_reg;
        end
        pkt_ex1 <= pkt_ex0;
        rob_ex1 <= rob_ex0;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_ex1 <= 1'b0;
            wr_en_ex1 <= 1'b0;
        end else begin
            valid_ex1 <= valid_ex0 & !br_mispred_rb1;
            wr_en_ex1 <= valid_ex0 & wr_en_ex0 & !br_mispred_rb1;
        end
    end

    assign ro_valid   = valid_ex1;
    assign ro_result  = rob_ex1;
    assign prf_wr_en  = wr_en_ex1;
    assign prf_wr_pkt = pkt_ex1;

endmodule

// File: exe_cfg.svh
`ifndef EXE_CFG_SVH
`define EXE_CFG_SVH

// Datapath width
`define EXE_XLEN 32

// Physical register and ROB id widths
`define EXE_PRF_W 6
`define EXE_ROB_W 5

// One quotient bit per step
`define EXE_DIV_STEPS `EXE_XLEN
`define EXE_DIV_CNT_W ($clog2(`EXE_DIV_STEPS))

`endif

// File: exe_top.sv
`include "exe_cfg.svh"

module exe_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  iss_valid,
    input  instr_pkg::t_uop       iss_uop,
    input  logic [`EXE_XLEN-1:0]  iss_src1,
    input  logic [`EXE_XLEN-1:0]  iss_src2,
    input  logic [`EXE_XLEN-1:0]  iss_imm,
    input  instr_pkg::t_optype    iss_src2_kind,
    input  logic                  iss_dst_reg,
    input  logic [`EXE_PRF_W-1:0] iss_pdst,
    input  logic [`EXE_ROB_W-1:0] iss_robid,
    input  logic [`EXE_XLEN-1:0]  iss_pc,
    input  logic                  iss_pred_taken,
    output logic                  iss_ready,
    input  logic                  br_mispred_rb1,
    output logic                  prf_wr_en,
    output rob_pkg::t_prf_wr_pkt  prf_wr_pkt,
    output logic                  ro_valid,
    output rob_pkg::t_rob_result  ro_result
);
    import instr_pkg::*;

    t_uinstr uinstr;

    assign uinstr.valid      = iss_valid;
    assign uinstr.uop        = iss_uop;
    assign uinstr.src2_kind  = iss_src2_kind;
    assign uinstr.imm        = iss_imm;
    assign uinstr.dst_reg    = iss_dst_reg;
    assign uinstr.pc         = iss_pc;
    assign uinstr.pred_taken = iss_pred_taken;

    exe u_exe (
        .clk            (clk),
        .rst_n          (rst_n),
        .iss_valid      (iss_valid),
        .iss_uinstr     (uinstr),
        .iss_src1       (iss_src1),
        .iss_src2       (iss_src2),
        .iss_pdst       (iss_pdst),
        .iss_robid      (iss_robid),
        .br_mispred_rb1 (br_mispred_rb1),
        .iss_ready      (iss_ready),
        .prf_wr_en      (prf_wr_en),
        .prf_wr_pkt     (prf_wr_pkt),
        .ro_valid       (ro_valid),
        .ro_result      (ro_result)
    );

endmodule

// File: exu_if.sv
`include "exe_cfg.svh"

interface exu_if;
    import instr_pkg::*;

    // Valid only on the accepting edge
    logic                 issue;
    t_uinstr              uinstr;
    logic [`EXE_XLEN-1:0] src1val;
    logic [`EXE_XLEN-1:0] src2val;

    modport exe_mp (
        output issue,
        output uinstr,
        output src1val,
        output src2val
    );

    modport unit_mp (
        input issue,
        input uinstr,
        input src1val,
        input src2val
    );

endinterface

// File: ialu.sv
`include "exe_cfg.svh"

module ialu (
    exu_if.unit_mp               u,
    output logic                 resvld,
    output logic [`EXE_XLEN-1:0] result
);
    import instr_pkg::*;

    logic [`EXE_XLEN-1:0] a;
    logic [`EXE_XLEN-1:0] b;
    logic [4:0]           shamt;

    assign a     = u.src1val;
    assign b     = u.src2val;
    assign shamt = b[4:0];

    assign resvld = u.issue & (u.uinstr.uop inside {
        U_ADD, U_SUB, U_AND, U_OR, U_XOR, U_SLL, U_SRL, U_SRA, U_SLT, U_SLTU
    });

    always_comb begin
        case (u.uinstr.uop)
            U_ADD:   result = a + b;
            U_SUB:   result = a - b;
            U_AND:   result = a & b;
            U_OR:    result = a | b;
            U_XOR:   result = a ^ b;
            U_SLL:   result = a << shamt;
            U_SRL:   result = a >> shamt;
            U_SRA:   result = $signed(a) >>> shamt;
            U_SLT: begin
                result = '0;
                result[0] = $signed(a) < $signed(b);
            end
            U_SLTU: begin
                result = '0;
                result[0] = a < b;
            end
            default: result = '0;
        endcase
    end

endmodule

// File: ibr.sv
`include "exe_cfg.svh"

module ibr (
    exu_if.unit_mp               u,
    output logic                 resvld,
    output logic [`EXE_XLEN-1:0] br_tgt,
    output logic                 br_mispred
);
    import instr_pkg::*;

    logic                 taken;
    logic                 equal;
    logic                 less;
    logic [`EXE_XLEN-1:0] pc;

    assign pc     = u.uinstr.pc;
    assign resvld = u.issue & (u.uinstr.uop inside {U_BEQ, U_BNE, U_BLT, U_BGE});

    assign equal = u.src1val == u.src2val;
    assign less  = $signed(u.src1val) < $signed(u.src2val);

    always_comb begin
        case (u.uinstr.uop)
            U_BEQ:   taken = equal;
            U_BNE:   taken = !equal;
            U_BLT:   taken = less;
            U_BGE:   taken = !less;
            default: taken = 1'b0;
        endcase
    end

    // Fall-through is the next sequential instruction
    assign br_tgt = taken ? pc + u.uinstr.imm : pc + `EXE_XLEN'd4;

    assign br_mispred = taken != u.uinstr.pred_taken;

endmodule

// File: idiv.sv
`include "exe_cfg.svh"

module idiv (
    input  logic                 clk,
    input  logic                 rst_n,
    exu_if.unit_mp               u,
    input  logic                 flush,
    output logic                 busy,
    output logic                 done,
    output logic [`EXE_XLEN-1:0] result
);
    import instr_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        DIVIDE,
        DONE
    } t_div_state;

    t_div_state                state;
    logic [`EXE_DIV_CNT_W-1:0] step;
    logic                      start;
    logic                      want_rem;
    logic [`EXE_XLEN-1:0]      divisor;
    logic [`EXE_XLEN-1:0]      quo;
    logic [`EXE_XLEN-1:0]      rem;
    logic [`EXE_XLEN:0]        partial;
    logic [`EXE_XLEN:0]        trial;

    assign start = u.issue & (u.uinstr.uop inside {U_DIVU, U_REMU});

    // Shift the next dividend bit into the partial remainder
    assign partial = {rem, quo[`EXE_XLEN-1]};
    assign trial   = partial - {1'b0, divisor};

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            state <= IDLE;
            step  <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= DIVIDE;
                        step  <= '0;
                    end
                end
                DIVIDE: begin
                    step <= step + 1'b1;
                    if (step == `EXE_DIV_CNT_W'(`EXE_DIV_STEPS - 1)) begin
                        state <= DONE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // A zero divisor never underflows, which yields all ones and the dividend
    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            quo      <= u.src1val;
            rem      <= '0;
            divisor  <= u.src2val;
            want_rem <= u.uinstr.uop == U_REMU;
        end else if (state == DIVIDE) begin
            if (!trial[`EXE_XLEN]) begin
                rem <= trial[`EXE_XLEN-1:0];
                quo <= {quo[`EXE_XLEN-2:0], 1'b1};
            end else begin
                rem <= partial[`EXE_XLEN-1:0];
                quo <= {quo[`EXE_XLEN-2:0], 1'b0};
            end
        end
    end

    assign busy   = state != IDLE;
    assign done   = state == DONE;
    assign result = want_rem ? rem : quo;

endmodule

// File: instr_pkg.sv
`include "exe_cfg.svh"

package instr_pkg;

    typedef enum logic [4:0] {
        U_ADD,
        U_SUB,
        U_AND,
        U_OR,
        U_XOR,
        U_SLL,
        U_SRL,
        U_SRA,
        U_SLT,
        U_SLTU,
        U_BEQ,
        U_BNE,
        U_BLT,
        U_BGE,
        U_DIVU,
        U_REMU,
        U_INVALID,
        U_ECALL
    } t_uop;

    // Kind of the second operand
    typedef enum logic [1:0] {
        OP_NONE,
        OP_REG,
        OP_IMM
    } t_optype;

    typedef struct packed {
        logic                 valid;
        t_uop                 uop;
        t_optype              src2_kind;
        logic [`EXE_XLEN-1:0] imm;
        logic                 dst_reg;
        logic [`EXE_XLEN-1:0] pc;
        logic                 pred_taken;
    } t_uinstr;

endpackage

// File: rob_pkg.sv
`include "exe_cfg.svh"

package rob_pkg;

    // Register file write
    typedef struct packed {
        logic [`EXE_PRF_W-1:0] pdst;
        logic [`EXE_XLEN-1:0]  data;
    } t_prf_wr_pkt;

    // Completion report to the ROB
    typedef struct packed {
        logic [`EXE_ROB_W-1:0] robid;
        logic                  mispred;
    } t_rob_result;

endpackage

// File: run.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f compile.f --top-module tb_exe -o tb_exe
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/tb_exe
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit $status
fi

exit 0

// File: tb_exe.sv
`include "exe_cfg.svh"

module tb_exe;
    import instr_pkg::*;
    import rob_pkg::*;

    localparam int NUM_OPS    = 400;
    localparam int WAIT_LIMIT = 4 * `EXE_DIV_STEPS;

    // One predicted completion
    typedef struct {
        int          seq;
        t_uop        uop;
        int          cyc;
        logic        wr_en;
        t_prf_wr_pkt wr;
        t_rob_result rob;
    } t_expect;

    logic                  clk;
    logic                  rst_n;
    logic                  iss_valid;
    t_uop                  iss_uop;
    logic [`EXE_XLEN-1:0]  iss_src1;
    logic [`EXE_XLEN-1:0]  iss_src2;
    logic [`EXE_XLEN-1:0]  iss_imm;
    t_optype               iss_src2_kind;
    logic                  iss_dst_reg;
    logic [`EXE_PRF_W-1:0] iss_pdst;
    logic [`EXE_ROB_W-1:0] iss_robid;
    logic [`EXE_XLEN-1:0]  iss_pc;
    logic                  iss_pred_taken;
    logic                  iss_ready;
    logic                  br_mispred_rb1;
    logic                  prf_wr_en;
    t_prf_wr_pkt           prf_wr_pkt;
    logic                  ro_valid;
    t_rob_result           ro_result;

    t_expect exp_q[$];
    int      cyc;
    int      seq;
    integer  seed;

    exe_top u_exe_top (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("ERROR %s expected %0b actual %0b", name, exp, act));
        end
    endtask

    task automatic check_wr(input string name, input t_prf_wr_pkt exp, input t_prf_wr_pkt act);
        if (act !== exp) begin
            abort_run($sformatf("ERROR %s prf_wr_pkt expected pdst %0d data %h actual pdst %0d data %h",
                name, exp.pdst, exp.data, act.pdst, act.data));
        end
    endtask

    task automatic check_rob(input string name, input t_rob_result exp, input t_rob_result act);
        if (act !== exp) begin
            abort_run($sformatf("ERROR %s ro_result expected robid %0d mispred %0b actual robid %0d mispred %0b",
                name, exp.robid, exp.mispred, act.robid, act.mispred));
        end
    endtask

    // Reference model for the op currently on the issue ports
    function automatic t_expect predict(input int n, input int at);
        t_expect              e;
        logic [`EXE_XLEN-1:0] b;
        logic                 taken;
        b = iss_src2_kind == OP_REG ? iss_src2 : (iss_src2_kind == OP_IMM ? iss_imm : '0);
        taken = 1'b0;
        e.seq = n;
        e.uop = iss_uop;
        e.cyc = at;
        e.wr_en = iss_dst_reg;
        e.wr.pdst = iss_pdst;
        e.wr.data = '0;
        e.rob.robid = iss_robid;
        e.rob.mispred = 1'b0;
        case (iss_uop)
            U_ADD:  e.wr.data = iss_src1 + b;
            U_SUB:  e.wr.data = iss_src1 - b;
            U_AND:  e.wr.data = iss_src1 & b;
            U_OR:   e.wr.data = iss_src1 | b;
            U_XOR:  e.wr.data = iss_src1 ^ b;
            U_SLL:  e.wr.data = iss_src1 << b[4:0];
            U_SRL:  e.wr.data = iss_src1 >> b[4:0];
            U_SRA:  e.wr.data = $unsigned($signed(iss_src1) >>> b[4:0]);
            U_SLT:  e.wr.data = ($signed(iss_src1) < $signed(b)) ? 32'd1 : 32'd0;
            U_SLTU: e.wr.data = (iss_src1 < b) ? 32'd1 : 32'd0;
            U_BEQ, U_BNE, U_BLT, U_BGE: begin
                case (iss_uop)
                    U_BEQ:   taken = iss_src1 == b;
                    U_BNE:   taken = iss_src1 != b;
                    U_BLT:   taken = $signed(iss_src1) < $signed(b);
                    default: taken = $signed(iss_src1) >= $signed(b);
                endcase
                e.wr.data = taken ? iss_pc + iss_imm : iss_pc + 32'd4;
                e.rob.mispred = taken != iss_pred_taken;
                e.wr_en = 1'b0;
            end
            U_DIVU: begin
                e.wr.data = (b == '0) ? '1 : iss_src1 / b;
                e.cyc = at + `EXE_DIV_STEPS + 1;
            end
            U_REMU: begin
                e.wr.data = (b == '0) ? iss_src1 : iss_src1 % b;
                e.cyc = at + `EXE_DIV_STEPS + 1;
            end
            default: e.wr_en = 1'b0;
        endcase
        return e;
    endfunction

    // Check outputs at the falling edge, then account for the rising edge
    task automatic tick(output bit accepted);
        t_expect e;
        bit      div_pending;
        logic    ready_s;
        logic    valid_s;
        logic    flush_s;
        string   name;
        @(negedge clk);
        div_pending = 1'b0;
        foreach (exp_q[i]) begin
            if (exp_q[i].uop inside {U_DIVU, U_REMU} && exp_q[i].cyc > cyc) begin
                div_pending = 1'b1;
            end
        end
        check_flag($sformatf("iss_ready cycle %0d", cyc), !div_pending, iss_ready);
        if (exp_q.size() > 0 && exp_q[0].cyc == cyc) begin
            e = exp_q.pop_front();
            name = $sformatf("%s #%0d", e.uop.name(), e.seq);
            check_flag({name, " ro_valid"}, 1'b1, ro_valid);
            check_flag({name, " prf_wr_en"}, e.wr_en, prf_wr_en);
            check_wr(name, e.wr, prf_wr_pkt);
            check_rob(name, e.rob, ro_result);
        end else begin
            check_flag($sformatf("ro_valid cycle %0d", cyc), 1'b0, ro_valid);
            check_flag($sformatf("prf_wr_en cycle %0d", cyc), 1'b0, prf_wr_en);
        end
        ready_s = iss_ready;
        valid_s = iss_valid;
        flush_s = br_mispred_rb1;
        @(posedge clk);
        cyc++;
        accepted = valid_s && ready_s;
        // Flush cancels everything still in flight and the op taken at this edge
        if (flush_s) begin
            exp_q.delete();
        end else if (accepted) begin
            exp_q.push_back(predict(seq, cyc));
        end
        if (accepted) begin
            seq++;
        end
    endtask

    task automatic drive_random_op();
        iss_valid      <= 1'b1;
        iss_uop        <= t_uop'(5'($unsigned($random(seed)) % 18));
        iss_src1       <= $random(seed);
        iss_src2       <= ($unsigned($random(seed)) % 6 == 0) ?
                          32'($unsigned($random(seed)) % 4) : $random(seed);
        iss_imm        <= $random(seed);
        iss_src2_kind  <= t_optype'(2'($unsigned($random(seed)) % 3));
        iss_dst_reg    <= 1'($random(seed));
        iss_pdst       <= `EXE_PRF_W'($random(seed));
        iss_robid      <= `EXE_ROB_W'($random(seed));
        iss_pc         <= $random(seed);
        iss_pred_taken <= 1'($random(seed));
    endtask

    initial begin
        bit accepted;
        int waited;
        seed           = 32'h8f35;
        cyc            = 0;
        seq            = 0;
        rst_n          = 1'b0;
        iss_valid      = 1'b0;
        iss_uop        = U_ADD;
        iss_src1       = '0;
        iss_src2       = '0;
        iss_imm        = '0;
        iss_src2_kind  = OP_REG;
        iss_dst_reg    = 1'b0;
        iss_pdst       = '0;
        iss_robid      = '0;
        iss_pc         = '0;
        iss_pred_taken = 1'b0;
        br_mispred_rb1 = 1'b0;

        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_flag("reset ro_valid", 1'b0, ro_valid);
        check_flag("reset prf_wr_en", 1'b0, prf_wr_en);
        check_flag("reset iss_ready", 1'b1, iss_ready);
        @(posedge clk);

        for (int n = 0; n < NUM_OPS; n++) begin
            if ($unsigned($random(seed)) % 8 == 0) begin
                iss_valid      <= 1'b0;
                br_mispred_rb1 <= 1'b0;
                tick(accepted);
            end else begin
                drive_random_op();
                waited = 0;
                accepted = 1'b0;
                // Op stays on the port until the stage takes it
                while (!accepted) begin
                    br_mispred_rb1 <= ($unsigned($random(seed)) % 40) == 0;
                    tick(accepted);
                    waited++;
                    if (!accepted && waited > WAIT_LIMIT) begin
                        abort_run($sformatf("op %0d was not accepted within %0d cycles",
                            seq, WAIT_LIMIT));
                    end
                end
            end
        end

        iss_valid      <= 1'b0;
        br_mispred_rb1 <= 1'b0;
        waited = 0;
        while (exp_q.size() > 0) begin
            tick(accepted);
            waited++;
            if (waited > WAIT_LIMIT) begin
                abort_run("pending results did not appear within the cycle limit");
            end
        end
        repeat (2) tick(accepted);

        $display("Verification passed");
        $finish;
    end

endmodule
